//--- design/bbc_mem_settings.svh
/*
 * BBC memory subsystem settings
 * widths and sizes of the CPU address map and the ROM/RAM stores
 */
`ifndef BBC_MEM_SETTINGS_SVH
`define BBC_MEM_SETTINGS_SVH

// ====================
// address and data
// ====================
// CPU address, bit 18 picks RAM over ROM
`define BBC_ADDR_W 19
`define BBC_DATA_W 8
// byte offset inside one 16K bank
`define BBC_SLOT_ADDR_W 14
// loader address, slot number then offset
`define BBC_LOAD_ADDR_W 18

// ====================
// store sizes
// ====================
// physical ROM slots, model B 0..3 and Master 4..13
`define BBC_ROM_SLOTS 14
`define BBC_ROM_BYTES ((`BBC_ROM_SLOTS) << (`BBC_SLOT_ADDR_W))
`define BBC_RAM_BYTES 212992

`endif

//--- design/apb_pkg.sv
/*
 * APB bus types for the memory subsystem
 * address/data vectors plus the arbiter and loader FSM states
 */
`include "bbc_mem_settings.svh"

package apb_pkg;

	// physical address, region bit then 18 offset bits
	typedef logic [`BBC_ADDR_W-1:0] apb_addr_t;
	typedef logic [`BBC_DATA_W-1:0] apb_data_t;

	// grant owner of the shared store
	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_CPU,
		ARB_LOAD
	} arb_state_e;

	// loader walk through one APB write
	typedef enum logic [1:0] {
		LOAD_IDLE,
		LOAD_SETUP,
		LOAD_ACCESS
	} load_state_e;

endpackage

//--- design/bbc_mem_pkg.sv
/*
 * BBC memory map types
 * machine model, address region and physical slot numbers
 */
`include "bbc_mem_settings.svh"

package bbc_mem_pkg;

	// machine model, latched during reset
	typedef enum logic [0:0] {
		MODEL_B      = 1'b0,
		MODEL_MASTER = 1'b1
	} model_e;

	// region picked by address bit 18
	typedef enum logic [0:0] {
		REGION_ROM = 1'b0,
		REGION_RAM = 1'b1
	} region_e;

	// physical ROM slot, 16K each
	typedef logic [3:0] rom_slot_t;

	// CPU side address and data
	typedef logic [`BBC_ADDR_W-1:0] bbc_addr_t;
	typedef logic [`BBC_DATA_W-1:0] bbc_data_t;

endpackage

//--- design/apb_if.sv
/*
 * APB link between requesters, arbiter and store
 */
interface apb_if import apb_pkg::*; ();

	// request side
	logic      psel;
	logic      penable;
	logic      pwrite;
	apb_addr_t paddr;
	apb_data_t pwdata;

	// response side
	apb_data_t prdata;
	logic      pready;

	modport requester (
		output psel,
		output penable,
		output pwrite,
		output paddr,
		output pwdata,
		input  prdata,
		input  pready
	);

	modport completer (
		input  psel,
		input  penable,
		input  pwrite,
		input  paddr,
		input  pwdata,
		output prdata,
		output pready
	);

endinterface

//--- design/cpu_bank_port.sv
/*
 * CPU bank port: model latch and bank remap onto physical ROM slots,
 * forwards RAM and mapped ROM reads, answers the rest locally
 */
`include "bbc_mem_settings.svh"

module cpu_bank_port import bbc_mem_pkg::*, apb_pkg::*; (
	input  logic      clk_sys,
	input  logic      rst_n,
	input  model_e    model_sel,
	input  logic      cpu_psel,
	input  logic      cpu_penable,
	input  logic      cpu_pwrite,
	input  bbc_addr_t cpu_paddr,
	input  bbc_data_t cpu_pwdata,
	output bbc_data_t cpu_prdata,
	output logic      cpu_pready,
	apb_if.requester  mem
);

	// marks a bank with no ROM behind it
	localparam rom_slot_t slot_none = 4'hF;

	model_e    model_q;
	region_e   region;
	logic [3:0] bank;
	rom_slot_t slot;
	logic      mapped;
	logic      fwd;
	apb_addr_t phys_addr;

	// model follows the select for as long as reset is held
	always_ff @(posedge clk_sys) begin
		if (!rst_n)
			model_q <= model_sel;
	end

	assign region = region_e'(cpu_paddr[`BBC_ADDR_W-1]);
	assign bank   = cpu_paddr[`BBC_LOAD_ADDR_W-1:`BBC_SLOT_ADDR_W];

	// ====================
	// slot tables
	// ====================
	always_comb begin
		slot = slot_none;
		if (model_q == MODEL_B) begin
			case (bank)
				4'b0100: slot = 4'd0;
				4'b1000: slot = 4'd1;
				4'b1110: slot = 4'd2;
				4'b1111: slot = 4'd3;
				default: slot = slot_none;
			endcase
		end else begin
			// Master keeps its own ten slots above the model B set
			case (bank)
				4'b0010: slot = 4'd4;
				4'b0011: slot = 4'd5;
				4'b0100: slot = 4'd6;
				4'b1001: slot = 4'd7;
				4'b1010: slot = 4'd8;
				4'b1011: slot = 4'd9;
				4'b1100: slot = 4'd10;
				4'b1101: slot = 4'd11;
				4'b1110: slot = 4'd12;
				4'b1111: slot = 4'd13;
				default: slot = slot_none;
			endcase
		end
	end

	assign mapped = (slot != slot_none);

	// RAM keeps its offset, ROM gets slot times 16K plus low bits
	assign phys_addr = (region == REGION_RAM) ?
		{REGION_RAM, cpu_paddr[`BBC_LOAD_ADDR_W-1:0]} :
		{REGION_ROM, slot, cpu_paddr[`BBC_SLOT_ADDR_W-1:0]};

	// ROM writes and unmapped reads never reach the store
	assign fwd = (region == REGION_RAM) || (!cpu_pwrite && mapped);

	// ====================
	// APB relay
	// ====================
	assign mem.psel    = cpu_psel & fwd;
	assign mem.penable = cpu_penable & fwd;
	assign mem.pwrite  = cpu_pwrite;
	assign mem.paddr   = phys_addr;
	assign mem.pwdata  = cpu_pwdata;

	// local answers finish in the first access cycle, read as zero
	assign cpu_pready = fwd ? mem.pready : (cpu_psel & cpu_penable);
	assign cpu_prdata = fwd ? mem.prdata : '0;

	// remap must never hand the store the unmapped marker
	a_fwd_slot_valid: assert property (@(posedge clk_sys) disable iff (!rst_n)
		mem.psel && (mem.paddr[`BBC_ADDR_W-1] == REGION_ROM) |->
		mem.paddr[`BBC_LOAD_ADDR_W-1:`BBC_SLOT_ADDR_W] < `BBC_ROM_SLOTS);

endmodule

//--- design/rom_loader.sv
/*
 * ROM loader: takes download bytes over valid/ready
 * and writes each one into its ROM slot as an APB transfer
 */
`include "bbc_mem_settings.svh"

module rom_loader import bbc_mem_pkg::*, apb_pkg::*; (
	input  logic                        clk_sys,
	input  logic                        rst_n,
	input  logic                        load_valid,
	input  logic [`BBC_LOAD_ADDR_W-1:0] load_addr,
	input  bbc_data_t                   load_data,
	output logic                        load_ready,
	apb_if.requester                    mem
);

	load_state_e state_q;
	load_state_e state_d;
	logic        ready_q;
	logic        take;
	logic [`BBC_LOAD_ADDR_W-1:0] addr_q;
	bbc_data_t   data_q;

	// byte handshake
	assign take = load_valid & ready_q;

	always_comb begin
		state_d = state_q;
		case (state_q)
			LOAD_IDLE:   if (take) state_d = LOAD_SETUP;
			LOAD_SETUP:  state_d = LOAD_ACCESS;
			// held here while the arbiter serves the CPU
			LOAD_ACCESS: if (mem.pready) state_d = LOAD_IDLE;
			default:     state_d = LOAD_IDLE;
		endcase
	end

	// ready is registered so it stays low through reset
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			state_q <= LOAD_IDLE;
			ready_q <= 1'b0;
		end else begin
			state_q <= state_d;
			ready_q <= (state_d == LOAD_IDLE);
		end
	end

	// captured byte and target
	always_ff @(posedge clk_sys) begin
		if (take) begin
			addr_q <= load_addr;
			data_q <= load_data;
		end
	end

	assign load_ready  = ready_q;
	assign mem.psel    = (state_q != LOAD_IDLE);
	assign mem.penable = (state_q == LOAD_ACCESS);
	assign mem.pwrite  = 1'b1;
	assign mem.paddr   = {REGION_ROM, addr_q};
	assign mem.pwdata  = data_q;

	// waiting access keeps its address and byte
	a_hold_stable: assert property (@(posedge clk_sys) disable iff (!rst_n)
		mem.psel && mem.penable && !mem.pready |=>
		$stable(mem.paddr) && $stable(mem.pwdata));

endmodule

//--- design/mem_arbiter.sv
/*
 * two-way APB arbiter, loader wins ties
 * runs its own setup/access toward the store, loser waits in access
 */
module mem_arbiter import apb_pkg::*; (
	input  logic      clk_sys,
	input  logic      rst_n,
	apb_if.completer  cpu,
	apb_if.completer  load,
	apb_if.requester  mem
);

	arb_state_e state_q;
	arb_state_e state_d;
	// store side is in its access phase
	logic       acc_q;
	logic       grant_load;

	// ====================
	// grant FSM
	// ====================
	always_comb begin
		state_d = state_q;
		case (state_q)
			ARB_IDLE: begin
				if (load.psel)
					state_d = ARB_LOAD;
				else if (cpu.psel)
					state_d = ARB_CPU;
			end
			// grant held until the store ends the transfer
			ARB_CPU,
			ARB_LOAD: if (mem.pready) state_d = ARB_IDLE;
			default:  state_d = ARB_IDLE;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			state_q <= ARB_IDLE;
			acc_q   <= 1'b0;
		end else begin
			state_q <= state_d;
			// first granted cycle is the store setup
			acc_q   <= (state_q != ARB_IDLE) && !mem.pready;
		end
	end

	// ====================
	// relay to the store
	// ====================
	assign grant_load = (state_q == ARB_LOAD);

	assign mem.psel    = (state_q != ARB_IDLE);
	assign mem.penable = acc_q;
	assign mem.pwrite  = grant_load ? load.pwrite : cpu.pwrite;
	assign mem.paddr   = grant_load ? load.paddr  : cpu.paddr;
	assign mem.pwdata  = grant_load ? load.pwdata : cpu.pwdata;

	// read data shared, pready only to the owner
	assign cpu.prdata  = mem.prdata;
	assign load.prdata = mem.prdata;
	assign cpu.pready  = (state_q == ARB_CPU) & mem.pready;
	assign load.pready = grant_load & mem.pready;

	// each store completion lands on exactly one requester
	a_one_owner: assert property (@(posedge clk_sys) disable iff (!rst_n)
		mem.pready |-> (cpu.pready ^ load.pready));

endmodule

//--- design/mem_store.sv
/*
 * shared ROM and RAM store behind one APB completer
 * writes in access 1, read data registered, pready in access 2
 */
`include "bbc_mem_settings.svh"

module mem_store import bbc_mem_pkg::*; (
	input  logic     clk_sys,
	input  logic     rst_n,
	apb_if.completer bus
);

	bbc_data_t rom [`BBC_ROM_BYTES];
	bbc_data_t ram [`BBC_RAM_BYTES];

	region_e   region;
	logic [`BBC_LOAD_ADDR_W-1:0] offset;
	logic      rom_hit;
	logic      ram_hit;
	logic      acc_first;
	logic      pready_q;
	bbc_data_t rdata_q;

	assign region = region_e'(bus.paddr[`BBC_ADDR_W-1]);
	assign offset = bus.paddr[`BBC_LOAD_ADDR_W-1:0];

	// out-of-range offsets read zero, writes dropped
	assign rom_hit = (offset < `BBC_ROM_BYTES);
	assign ram_hit = (offset < `BBC_RAM_BYTES);

	// first access cycle only
	assign acc_first = bus.psel & bus.penable & ~pready_q;

	always_ff @(posedge clk_sys) begin
		if (!rst_n)
			pready_q <= 1'b0;
		else
			pready_q <= acc_first;
	end

	// ====================
	// arrays
	// ====================
	always_ff @(posedge clk_sys) begin
		if (acc_first && bus.pwrite && region == REGION_ROM && rom_hit)
			rom[offset] <= bus.pwdata;
	end

	always_ff @(posedge clk_sys) begin
		if (acc_first && bus.pwrite && region == REGION_RAM && ram_hit)
			ram[offset] <= bus.pwdata;
	end

	always_ff @(posedge clk_sys) begin
		if (acc_first) begin
			if (region == REGION_ROM)
				rdata_q <= rom_hit ? rom[offset] : '0;
			else
				rdata_q <= ram_hit ? ram[offset] : '0;
		end
	end

	assign bus.prdata = rdata_q;
	assign bus.pready = pready_q;

endmodule

//--- design/bbc_mem_top.sv
/*
 * BBC memory subsystem top: CPU port and ROM loader
 * share one ROM/RAM store through an APB arbiter
 */
`include "bbc_mem_settings.svh"

module bbc_mem_top import bbc_mem_pkg::*; (
	input  logic                        clk_sys,
	input  logic                        rst_n,
	input  model_e                      model_sel,
	// CPU APB side
	input  logic                        cpu_psel,
	input  logic                        cpu_penable,
	input  logic                        cpu_pwrite,
	input  bbc_addr_t                   cpu_paddr,
	input  bbc_data_t                   cpu_pwdata,
	output bbc_data_t                   cpu_prdata,
	output logic                        cpu_pready,
	// download stream
	input  logic                        load_valid,
	input  logic [`BBC_LOAD_ADDR_W-1:0] load_addr,
	input  bbc_data_t                   load_data,
	output logic                        load_ready
);

	apb_if cpu_bus ();
	apb_if load_bus ();
	apb_if mem_bus ();

	cpu_bank_port u_cpu_bank_port (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.model_sel   (model_sel),
		.cpu_psel    (cpu_psel),
		.cpu_penable (cpu_penable),
		.cpu_pwrite  (cpu_pwrite),
		.cpu_paddr   (cpu_paddr),
		.cpu_pwdata  (cpu_pwdata),
		.cpu_prdata  (cpu_prdata),
		.cpu_pready  (cpu_pready),
		.mem         (cpu_bus.requester)
	);

	rom_loader u_rom_loader (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.load_valid (load_valid),
		.load_addr  (load_addr),
		.load_data  (load_data),
		.load_ready (load_ready),
		.mem        (load_bus.requester)
	);

	mem_arbiter u_mem_arbiter (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.cpu     (cpu_bus.completer),
		.load    (load_bus.completer),
		.mem     (mem_bus.requester)
	);

	mem_store u_mem_store (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.bus     (mem_bus.completer)
	);

endmodule

//--- verif/tb_bbc_mem.sv
/*
 * testbench for the BBC memory subsystem
 * loads ROM slots, drives CPU APB traffic, checks reads against a reference map
 */
`include "bbc_mem_settings.svh"

module tb_bbc_mem import bbc_mem_pkg::*; ();

	localparam int clk_period = 100;
	localparam int slot_bytes = 1 << `BBC_SLOT_ADDR_W;
	localparam int n_b_loads  = 16;
	localparam int n_m_loads  = 30;
	localparam int n_ram      = 16;
	localparam int n_conc     = 12;
	// every load and CPU transfer of all five tests
	localparam int n_xfers = 2 * n_b_loads + 12 + 2 * (n_m_loads + 1) + 1 +
		2 * n_ram + 4 + 3 * n_conc;
	// worst case 10 cycles each plus both resets
	localparam int watchdog_cycles = n_xfers * 10 + 50;

	logic      clk_sys;
	logic      rst_n;
	model_e    model_sel;
	logic      cpu_psel;
	logic      cpu_penable;
	logic      cpu_pwrite;
	bbc_addr_t cpu_paddr;
	bbc_data_t cpu_pwdata;
	bbc_data_t cpu_prdata;
	logic      cpu_pready;
	logic      load_valid;
	logic [`BBC_LOAD_ADDR_W-1:0] load_addr;
	bbc_data_t load_data;
	logic      load_ready;

	// ====================
	// expected memory
	// ====================
	bbc_data_t rom_exp [int];
	bbc_data_t ram_exp [int];
	model_e    model_cur = MODEL_B;
	bbc_data_t offered  = '0;
	bbc_data_t accepted = '0;
	logic      load_ready_q = 1'b0;
	int        reads_issued  = 0;
	int        reads_checked = 0;
	integer    seed = 75;

	// CPU bank that reaches each slot
	logic [3:0] bank_of_slot [14] = '{4'h4, 4'h8, 4'hE, 4'hF, 4'h2, 4'h3, 4'h4,
		4'h9, 4'hA, 4'hB, 4'hC, 4'hD, 4'hE, 4'hF};
	// banks with nothing behind them on model B
	logic [3:0] b_unmapped [12] = '{4'h0, 4'h1, 4'h2, 4'h3, 4'h5, 4'h6, 4'h7,
		4'h9, 4'hA, 4'hB, 4'hC, 4'hD};

	bbc_mem_top u_dut (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.model_sel   (model_sel),
		.cpu_psel    (cpu_psel),
		.cpu_penable (cpu_penable),
		.cpu_pwrite  (cpu_pwrite),
		.cpu_paddr   (cpu_paddr),
		.cpu_pwdata  (cpu_pwdata),
		.cpu_prdata  (cpu_prdata),
		.cpu_pready  (cpu_pready),
		.load_valid  (load_valid),
		.load_addr   (load_addr),
		.load_data   (load_data),
		.load_ready  (load_ready)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(clk_period / 2) clk_sys = ~clk_sys;
	end

	function automatic int rom_index(input rom_slot_t slot, input logic [13:0] off);
		return slot * slot_bytes + off;
	endfunction

	function automatic bbc_addr_t cpu_addr_of(input rom_slot_t slot, input logic [13:0] off);
		return {1'b0, bank_of_slot[slot], off};
	endfunction

	// reference map of what a CPU read of this address must return
	function automatic bbc_data_t ref_read(input model_e m, input bbc_addr_t a);
		int slot;
		int off;
		slot = -1;
		if (a[18]) begin
			off = a[17:0];
			if (off >= `BBC_RAM_BYTES || !ram_exp.exists(off))
				return '0;
			return ram_exp[off];
		end
		if (m == MODEL_B) begin
			case (a[17:14])
				4'b0100: slot = 0;
				4'b1000: slot = 1;
				4'b1110: slot = 2;
				4'b1111: slot = 3;
				default: slot = -1;
			endcase
		end else begin
			case (a[17:14])
				4'b0010: slot = 4;
				4'b0011: slot = 5;
				4'b0100: slot = 6;
				4'b1001: slot = 7;
				4'b1010: slot = 8;
				4'b1011: slot = 9;
				4'b1100: slot = 10;
				4'b1101: slot = 11;
				4'b1110: slot = 12;
				4'b1111: slot = 13;
				default: slot = -1;
			endcase
		end
		// unmapped bank reads as zero
		if (slot < 0)
			return '0;
		off = slot * slot_bytes + a[13:0];
		return rom_exp.exists(off) ? rom_exp[off] : '0;
	endfunction

	// ROM writes dropped and RAM kept only below its size
	function automatic void ref_write(input bbc_addr_t a, input bbc_data_t d);
		if (a[18] && a[17:0] < `BBC_RAM_BYTES)
			ram_exp[int'(a[17:0])] = d;
	endfunction

	// ====================
	// checks
	// ====================
	task automatic stop_run(input string why);
		$display("%s", why);
		$display("sim failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_data(input string name, input bbc_data_t got, input bbc_data_t exp);
		if (got !== exp)
			stop_run($sformatf("** Error: %s = 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic check_count(input string name, input bbc_data_t got, input bbc_data_t exp);
		if (got !== exp)
			stop_run($sformatf("** Error: %s = 0x%h, expected 0x%h", name, got, exp));
	endtask

	// every completed CPU read against the reference
	always @(posedge clk_sys) begin
		if (rst_n && cpu_psel && cpu_penable && cpu_pready && !cpu_pwrite) begin
			check_data($sformatf("cpu_prdata[%h]", cpu_paddr), cpu_prdata,
				ref_read(model_cur, cpu_paddr));
			reads_checked++;
		end
	end

	// each byte the loader takes drops load_ready for its write
	always @(posedge clk_sys) begin
		load_ready_q <= load_ready;
		if (rst_n && load_ready_q && !load_ready)
			accepted <= accepted + 8'd1;
	end

	initial begin
		#(watchdog_cycles * clk_period);
		$display("watchdog expired after %0d cycles, a transfer never finished",
			watchdog_cycles);
		$display("sim failed");
		$fatal(1, "timeout");
	end

	// ====================
	// drivers
	// ====================
	task automatic apply_reset(input model_e m);
		@(posedge clk_sys);
		rst_n     <= 1'b0;
		model_sel <= m;
		repeat (4) @(posedge clk_sys);
		rst_n     <= 1'b1;
		model_cur = m;
	endtask

	// one APB transfer that returns at the pready edge
	task automatic cpu_xfer(input logic wr, input bbc_addr_t a, input bbc_data_t d);
		@(posedge clk_sys);
		cpu_psel    <= 1'b1;
		cpu_penable <= 1'b0;
		cpu_pwrite  <= wr;
		cpu_paddr   <= a;
		cpu_pwdata  <= d;
		@(posedge clk_sys);
		cpu_penable <= 1'b1;
		@(posedge clk_sys);
		while (!cpu_pready)
			@(posedge clk_sys);
		cpu_psel    <= 1'b0;
		cpu_penable <= 1'b0;
	endtask

	task automatic cpu_read(input bbc_addr_t a);
		reads_issued++;
		cpu_xfer(1'b0, a, '0);
	endtask

	task automatic cpu_write(input bbc_addr_t a, input bbc_data_t d);
		cpu_xfer(1'b1, a, d);
		ref_write(a, d);
	endtask

	// valid held until the loader takes the byte
	task automatic load_byte(input rom_slot_t slot, input logic [13:0] off, input bbc_data_t d);
		rom_exp[rom_index(slot, off)] = d;
		offered = offered + 8'd1;
		@(posedge clk_sys);
		load_valid <= 1'b1;
		load_addr  <= {slot, off};
		load_data  <= d;
		@(posedge clk_sys);
		while (!load_ready)
			@(posedge clk_sys);
		load_valid <= 1'b0;
	endtask

	// loader back in idle means its last write landed
	task automatic drain_loader();
		@(posedge clk_sys);
		while (!load_ready)
			@(posedge clk_sys);
	endtask

	initial begin : stimulus
		int          i;
		int          j;
		int          k;
		rom_slot_t   slot;
		logic [13:0] off;
		logic [13:0] b_off0;
		logic [17:0] roff;
		bbc_addr_t   a;
		rom_slot_t   c_slot [n_conc];
		logic [13:0] c_off [n_conc];
		bbc_data_t   c_data [n_conc];
		bbc_addr_t   c_rd [n_conc];
		bbc_addr_t   b_reads [$];
		bbc_addr_t   m_reads [$];
		bbc_addr_t   ram_reads [$];

		rst_n       = 1'b0;
		model_sel   = MODEL_B;
		cpu_psel    = 1'b0;
		cpu_penable = 1'b0;
		cpu_pwrite  = 1'b0;
		cpu_paddr   = '0;
		cpu_pwdata  = '0;
		load_valid  = 1'b0;
		load_addr   = '0;
		load_data   = '0;

		// model B with slots 0..3
		apply_reset(MODEL_B);
		for (i = 0; i < n_b_loads; i++) begin
			slot = i / 4;
			off  = $random(seed);
			if (i == 0)
				b_off0 = off;
			load_byte(slot, off, $random(seed));
			b_reads.push_back(cpu_addr_of(slot, off));
		end
		drain_loader();
		foreach (b_reads[i])
			cpu_read(b_reads[i]);

		// unmapped banks read zero and ROM writes are dropped
		for (i = 0; i < 4; i++) begin
			off = $random(seed);
			a = {1'b0, (i == 0) ? 4'h0 : b_unmapped[$unsigned($random(seed)) % 12], off};
			cpu_read(a);
		end
		for (i = 0; i < 4; i++) begin
			cpu_write(b_reads[i * 4], $random(seed));
			cpu_read(b_reads[i * 4]);
		end

		// Master with slots 4..13
		apply_reset(MODEL_MASTER);
		for (i = 0; i < n_m_loads; i++) begin
			slot = 4 + i / 3;
			off  = $random(seed);
			load_byte(slot, off, $random(seed));
			m_reads.push_back(cpu_addr_of(slot, off));
		end
		// bank 0100 at the slot 0 offset must now reach slot 6
		load_byte(4'd6, b_off0, ~rom_exp[rom_index(4'd0, b_off0)]);
		m_reads.push_back(cpu_addr_of(4'd6, b_off0));
		drain_loader();
		foreach (m_reads[i])
			cpu_read(m_reads[i]);
		// bank 1000 belongs to model B only
		cpu_read(b_reads[4]);

		// RAM window
		for (i = 0; i < n_ram; i++) begin
			roff = $unsigned($random(seed)) % `BBC_RAM_BYTES;
			cpu_write({1'b1, roff}, $random(seed));
			ram_reads.push_back({1'b1, roff});
		end
		foreach (ram_reads[i])
			cpu_read(ram_reads[i]);
		for (i = 0; i < 2; i++) begin
			roff = `BBC_RAM_BYTES + $unsigned($random(seed)) % (262144 - `BBC_RAM_BYTES);
			cpu_write({1'b1, roff}, $random(seed));
			cpu_read({1'b1, roff});
		end

		// loader and CPU together with load targets kept apart from read targets
		for (i = 0; i < n_conc; i++) begin
			c_slot[i] = 4 + $unsigned($random(seed)) % 10;
			c_off[i]  = $random(seed);
			while (rom_exp.exists(rom_index(c_slot[i], c_off[i])))
				c_off[i] = $random(seed);
			c_data[i] = $random(seed);
			if (i % 2 == 0)
				c_rd[i] = m_reads[$unsigned($random(seed)) % m_reads.size()];
			else
				c_rd[i] = ram_reads[$unsigned($random(seed)) % ram_reads.size()];
		end
		fork
			for (j = 0; j < n_conc; j++)
				load_byte(c_slot[j], c_off[j], c_data[j]);
			for (k = 0; k < n_conc; k++)
				cpu_read(c_rd[k]);
		join
		drain_loader();
		for (i = 0; i < n_conc; i++)
			cpu_read(cpu_addr_of(c_slot[i], c_off[i]));
		repeat (2) @(posedge clk_sys);
		check_count("accepted", accepted, offered);

		if (reads_checked != reads_issued) begin
			stop_run($sformatf("compare process checked %0d reads but %0d were issued",
				reads_checked, reads_issued));
		end else begin
			$display("sim passed");
			$finish;
		end
	end

endmodule

//--- sources.f
+incdir+design
design/apb_pkg.sv
design/bbc_mem_pkg.sv
design/apb_if.sv
design/cpu_bank_port.sv
design/rom_loader.sv
design/mem_arbiter.sv
design/mem_store.sv
design/bbc_mem_top.sv
verif/tb_bbc_mem.sv

//--- Bender.yml
package:
  name: bbc_mem

sources:
  # memory subsystem RTL
  - include_dirs:
      - design
    files:
      - design/apb_pkg.sv
      - design/bbc_mem_pkg.sv
      - design/apb_if.sv
      - design/cpu_bank_port.sv
      - design/rom_loader.sv
      - design/mem_arbiter.sv
      - design/mem_store.sv
      - design/bbc_mem_top.sv
  # testbench
  - target: test
    include_dirs:
      - design
    files:
      - verif/tb_bbc_mem.sv
